/* Makefile */
VERILATOR  ?= verilator
TOP        := pal_tb
FILELIST   := tb.f
COMMON     := --timing --timescale 1ns/1ns --top-module $(TOP) -f $(FILELIST)
LINT_FLAGS := --lint-only $(COMMON)
SIM_FLAGS  := --binary --assert -j 0 $(COMMON)
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := CHECKS FAILED
SRCS       := $(shell grep -v '^+' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; \
	if [ $$status -ne 0 ]; then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/pal_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module pal_checker (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        dl_wr,
    input  logic                        downloading,
    input  pal_pkg::dl_addr_t           dl_addr,
    input  logic [pal_pkg::DW-1:0]      dl_data,
    input  logic [pal_pkg::PROM_AW-1:0] pxl_code,
    input  logic                        pxl_cen,
    input  logic [pal_pkg::DW-1:0]      red,
    input  logic [pal_pkg::DW-1:0]      green,
    input  logic [pal_pkg::DW-1:0]      blue,
    input  logic                        rgb_valid,
    input  logic [pal_pkg::DL_AW:0]     dl_count,
    output int                          errors,
    output int                          checks
);
    import pal_pkg::*;

    // all four proms in one array by flat download address
    logic [DW-1:0]      model [0:(2**DL_AW)-1];
    logic [3*DW-1:0]    exp_q [$];
    logic [PROM_AW-1:0] code_q [$];
    logic [3*DW-1:0]    want;
    logic [PROM_AW-1:0] code;
    // accepted byte that lands in the model one edge later
    logic               wr_pend;
    logic [DL_AW-1:0]   wr_addr;
    logic [DW-1:0]      wr_data;
    // model of the lookup stage
    logic               idx_vld;
    logic [DW-1:0]      idx;
    logic [PROM_AW-1:0] idx_code;
    logic [DL_AW:0]     exp_count;
    logic               prev_cen;
    logic               prev_rst;
    logic               vld_seen;
    int                 cen_gap;

    // reference model from colour index to red, green and blue
    function automatic logic [3*DW-1:0] colour_for_index(input logic [DW-1:0] index);
        return {model[{REG_RED, index}], model[{REG_GRN, index}], model[{REG_BLU, index}]};
    endfunction

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED t=%0t %s expected %0h got %0h", $time, name, exp, act);
        end
    endtask

    initial begin
        errors = 0;
        checks = 0;
        prev_cen = 1'b0;
        prev_rst = 1'b1;
        // proms power up cleared
        for (int i = 0; i < 2**DL_AW; i++) begin
            model[i] = '0;
        end
    end

    // mid-cycle sample where inputs and registered outputs are settled
    always @(negedge clk) begin
        if (rst) begin
            exp_q.delete();
            code_q.delete();
            wr_pend = 1'b0;
            idx_vld = 1'b0;
            exp_count = '0;
            vld_seen = 1'b0;
            cen_gap = 0;
        end else begin
            if (prev_rst) begin
                compare_value("pxl_cen", 32'(0), 32'(pxl_cen));
                compare_value("rgb_valid", 32'(0), 32'(rgb_valid));
            end
            // edges since reset or since the last enable
            cen_gap = prev_rst ? 0 : cen_gap + 1;
            if (pxl_cen) begin
                compare_value("pxl_cen spacing", 32'(PXL_DIV), 32'(cen_gap));
                cen_gap = 0;
            end else if (cen_gap >= PXL_DIV) begin
                errors++;
                $display("pixel enable missing at t=%0t", $time);
                cen_gap = 0;
            end
            // a result is due one edge after every enable from the second on
            if (prev_cen) begin
                compare_value("rgb_valid", 32'(exp_q.size() != 0), 32'(rgb_valid));
                if (exp_q.size() != 0) begin
                    want = exp_q.pop_front();
                    code = code_q.pop_front();
                    compare_value($sformatf("red (code %02h)", code), 32'(want[23:16]), 32'(red));
                    compare_value($sformatf("green (code %02h)", code), 32'(want[15:8]),
                                  32'(green));
                    compare_value($sformatf("blue (code %02h)", code), 32'(want[7:0]), 32'(blue));
                end
            end
            if (vld_seen && !rgb_valid) begin
                errors++;
                $display("rgb_valid dropped at t=%0t with the pipeline full", $time);
            end
            vld_seen = vld_seen || rgb_valid;
            // reads at the coming edge see the proms before that edge's write
            if (pxl_cen) begin
                if (idx_vld) begin
                    exp_q.push_back(colour_for_index(idx));
                    code_q.push_back(idx_code);
                end
                idx = model[{REG_LUT, pxl_code}];
                idx_code = pxl_code;
                idx_vld = 1'b1;
            end
            compare_value("dl_count", 32'(exp_count), 32'(dl_count));
            if (wr_pend) begin
                model[wr_addr] = wr_data;
            end
            // bytes outside a download are dropped
            wr_pend = dl_wr && downloading;
            wr_addr = dl_addr.flat;
            wr_data = dl_data;
            if (wr_pend) begin
                exp_count = exp_count + 1'b1;
            end
        end
        prev_cen = pxl_cen;
        prev_rst = rst;
    end

endmodule

`default_nettype wire

/* bench/pal_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module pal_tb;
    import pal_pkg::*;

    // cycles allowed for one pixel enable to show up
    localparam int CEN_TIMEOUT = 4 * PXL_DIV;

    logic               clk;
    logic               rst;
    logic               dl_wr;
    logic               downloading;
    dl_addr_t           dl_addr;
    logic [DW-1:0]      dl_data;
    logic [PROM_AW-1:0] pxl_code;
    logic               pxl_cen;
    logic [DW-1:0]      red;
    logic [DW-1:0]      green;
    logic [DW-1:0]      blue;
    logic               rgb_valid;
    logic [DL_AW:0]     dl_count;
    int                 chk_errors;
    int                 chk_checks;
    int                 seed;
    int                 timeouts;
    int                 err_mark;
    int                 total;

    pal_top dut0 (
        .clk(clk), .rst(rst), .dl_wr(dl_wr), .downloading(downloading),
        .dl_addr(dl_addr), .dl_data(dl_data), .pxl_code(pxl_code), .pxl_cen(pxl_cen),
        .red(red), .green(green), .blue(blue), .rgb_valid(rgb_valid), .dl_count(dl_count)
    );

    pal_checker chk0 (
        .clk(clk), .rst(rst), .dl_wr(dl_wr), .downloading(downloading),
        .dl_addr(dl_addr), .dl_data(dl_data), .pxl_code(pxl_code), .pxl_cen(pxl_cen),
        .red(red), .green(green), .blue(blue), .rgb_valid(rgb_valid), .dl_count(dl_count),
        .errors(chk_errors), .checks(chk_checks)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // to the drive point 2 ns after the edge
    // a new random code follows every pixel enable
    task automatic tick();
        @(posedge clk);
        #2;
        if (pxl_cen) begin
            pxl_code = PROM_AW'($random(seed));
        end
    endtask

    task automatic wait_enables(input int n);
        int waited;
        for (int i = 0; i < n; i++) begin
            waited = 0;
            tick();
            while (!pxl_cen && waited < CEN_TIMEOUT) begin
                tick();
                waited++;
            end
            if (!pxl_cen) begin
                timeouts++;
                $display("timeout at t=%0t, no pixel enable within %0d cycles", $time, CEN_TIMEOUT);
                break;
            end
        end
    endtask

    // one byte per cycle, linear from first or at random addresses
    task automatic download_bytes(input int first, input int n, input bit random_addr);
        for (int i = 0; i < n; i++) begin
            tick();
            dl_wr = 1'b1;
            dl_addr.flat = random_addr ? DL_AW'($random(seed)) : DL_AW'(first + i);
            dl_data = DW'($random(seed));
        end
        tick();
        dl_wr = 1'b0;
    endtask

    task automatic end_test(input string name);
        int now;
        now = chk_errors + timeouts;
        if (now == err_mark) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: failed with %0d errors", name, now - err_mark);
        end
        err_mark = now;
    endtask

    initial begin
        seed = 32'h3c8b_3ffe;
        timeouts = 0;
        err_mark = 0;
        rst = 1'b1;
        dl_wr = 1'b0;
        downloading = 1'b0;
        dl_addr = '0;
        dl_data = '0;
        pxl_code = '0;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        wait_enables(4);
        end_test("test 1 reset values and pixel enable rate");
        // every prom filled while pixels keep streaming
        downloading = 1'b1;
        download_bytes(0, 2**DL_AW, 1'b0);
        downloading = 1'b0;
        wait_enables(64);
        end_test("test 2 full download and lookup");
        download_bytes(0, 64, 1'b1);
        wait_enables(32);
        end_test("test 3 bytes outside a download dropped");
        wait_enables(200);
        end_test("test 4 pipelined code stream");
        // red region only, reads continue meanwhile
        downloading = 1'b1;
        download_bytes(int'(REG_RED) * (2**PROM_AW), 2**PROM_AW, 1'b0);
        downloading = 1'b0;
        wait_enables(48);
        end_test("test 5 red region reload while streaming");
        total = chk_errors + timeouts;
        $display("checks %0d, errors %0d, timeouts %0d", chk_checks, chk_errors, timeouts);
        if (total == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* logic/pal_cen_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module pal_cen_gen (
    input  logic clk,
    input  logic rst,
    output logic pxl_cen
);
    import pal_pkg::*;

    logic [PXL_CW-1:0] cnt;

    // modulo-PXL_DIV count, pulse registered on the last count
    // first pulse lands PXL_DIV edges after reset drops
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt     <= '0;
            pxl_cen <= 1'b0;
        end else begin
            pxl_cen <= (cnt == PXL_CW'(PXL_DIV-1));
            if (cnt == PXL_CW'(PXL_DIV-1)) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // never two enables back to back
    a_no_adjacent: assert property (@(posedge clk) disable iff (rst) pxl_cen |=> !pxl_cen);

endmodule

`default_nettype wire

/* logic/pal_dl_router.sv */
`timescale 1ns/1ns
`default_nettype none

module pal_dl_router (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        dl_wr,
    input  logic                        downloading,
    input  pal_pkg::dl_addr_t           dl_addr,
    input  logic [pal_pkg::DW-1:0]      dl_data,
    output logic [pal_pkg::NPROM-1:0]   prom_we,
    output logic [pal_pkg::PROM_AW-1:0] prom_addr,
    output logic [pal_pkg::DW-1:0]      prom_data,
    output logic [pal_pkg::DL_AW:0]     dl_count
);
    import pal_pkg::*;

    logic             accept;
    logic [NPROM-1:0] we_dec;

    // bytes outside a download are dropped
    assign accept = dl_wr && downloading;

    // region field to one-hot prom strobe
    always_comb begin
        we_dec = '0;
        we_dec[dl_addr.split.region] = 1'b1;
    end

    // control state, strobe lasts one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            prom_we  <= '0;
            dl_count <= '0;
        end else begin
            prom_we <= '0;
            if (accept) begin
                prom_we  <= we_dec;
                dl_count <= dl_count + 1'b1;
            end
        end
    end

    // payload, offset goes straight on as the prom address
    always_ff @(posedge clk) begin
        if (accept) begin
            prom_addr <= dl_addr.split.offset;
            prom_data <= dl_data;
        end
    end

    // at most one prom written per byte
    a_we_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(prom_we));
    // an accepted byte must carry a known address
    a_addr_known: assert property (@(posedge clk) disable iff (rst)
        accept |-> !$isunknown(dl_addr.flat));

endmodule

`default_nettype wire

/* logic/pal_lookup.sv */
`timescale 1ns/1ns
`default_nettype none

module pal_lookup (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        pxl_cen,
    input  logic [pal_pkg::PROM_AW-1:0] pxl_code,
    input  logic [pal_pkg::NPROM-1:0]   prom_we,
    input  logic [pal_pkg::PROM_AW-1:0] prom_addr,
    input  logic [pal_pkg::DW-1:0]      prom_data,
    output logic [pal_pkg::DW-1:0]      red,
    output logic [pal_pkg::DW-1:0]      green,
    output logic [pal_pkg::DW-1:0]      blue,
    output logic                        rgb_valid
);
    import pal_pkg::*;

    // colour index from the lookup stage
    logic [DW-1:0] lut_idx;
    logic [1:0]    vld;

    // stage 1: pixel code to colour index
    pal_prom lut_prom (
        .clk     (clk),
        .cen     (pxl_cen),
        .data    (prom_data),
        .rd_addr (pxl_code),
        .wr_addr (prom_addr),
        .we      (prom_we[REG_LUT]),
        .q       (lut_idx)
    );

    // stage 2: index to the three components, one enable later
    pal_prom red_prom (
        .clk     (clk),
        .cen     (pxl_cen),
        .data    (prom_data),
        .rd_addr (lut_idx),
        .wr_addr (prom_addr),
        .we      (prom_we[REG_RED]),
        .q       (red)
    );

    pal_prom grn_prom (
        .clk     (clk),
        .cen     (pxl_cen),
        .data    (prom_data),
        .rd_addr (lut_idx),
        .wr_addr (prom_addr),
        .we      (prom_we[REG_GRN]),
        .q       (green)
    );

    pal_prom blu_prom (
        .clk     (clk),
        .cen     (pxl_cen),
        .data    (prom_data),
        .rd_addr (lut_idx),
        .wr_addr (prom_addr),
        .we      (prom_we[REG_BLU]),
        .q       (blue)
    );

    // valid follows the two stages, moves only with the pixel enable
    always_ff @(posedge clk) begin
        if (rst) begin
            vld <= '0;
        end else if (pxl_cen) begin
            vld <= {vld[0], 1'b1};
        end
    end

    assign rgb_valid = vld[1];

    // output valid only steps on the cycle after an enable edge
    a_vld_on_cen: assert property (@(posedge clk) disable iff (rst)
        $changed(rgb_valid) |-> $past(pxl_cen));

endmodule

`default_nettype wire

/* logic/pal_pkg.sv */
`default_nettype none

package pal_pkg;

    // byte width of every prom word and colour component
    localparam int DW = 8;
    // 256 entries per prom
    localparam int PROM_AW = 8;
    // region field selects one of the four proms
    localparam int REGION_W = 2;
    localparam int DL_AW = REGION_W + PROM_AW;
    localparam int NPROM = 4;

    // region numbers, also the bit index into prom_we
    localparam logic [REGION_W-1:0] REG_LUT = 2'd0;
    localparam logic [REGION_W-1:0] REG_RED = 2'd1;
    localparam logic [REGION_W-1:0] REG_GRN = 2'd2;
    localparam logic [REGION_W-1:0] REG_BLU = 2'd3;

    // clk cycles per pixel enable
    localparam int PXL_DIV = 4;
    localparam int PXL_CW = $clog2(PXL_DIV);

    // download address split into region and offset
    typedef struct packed {
        logic [REGION_W-1:0] region;
        logic [PROM_AW-1:0]  offset;
    } dl_split_t;

    // same word seen as a linear byte address or as region/offset
    typedef union packed {
        logic [DL_AW-1:0] flat;
        dl_split_t        split;
    } dl_addr_t;

endpackage

`default_nettype wire

/* logic/pal_prom.sv */
`timescale 1ns/1ns
`default_nettype none

module pal_prom (
    input  logic                        clk,
    input  logic                        cen,
    input  logic [pal_pkg::DW-1:0]      data,
    input  logic [pal_pkg::PROM_AW-1:0] rd_addr,
    input  logic [pal_pkg::PROM_AW-1:0] wr_addr,
    input  logic                        we,
    output logic [pal_pkg::DW-1:0]      q
);
    import pal_pkg::*;

    logic [DW-1:0] mem [0:(2**PROM_AW)-1];

    // power-up contents are zero, as in FPGA block RAM
    initial begin
        for (int i = 0; i < 2**PROM_AW; i++) begin
            mem[i] = '0;
        end
        q = '0;
    end

    // read only on cen, so the output holds between pixels
    // write is not gated by cen, a download runs while reads are stopped
    always @(posedge clk) begin
        if (cen) begin
            q <= mem[rd_addr];
        end
        if (we) begin
            mem[wr_addr] <= data;
        end
    end

    // addresses must be known whenever a port is in use
    a_rd_addr_known: assert property (@(posedge clk) cen |-> !$isunknown(rd_addr));
    a_wr_addr_known: assert property (@(posedge clk) we |-> !$isunknown(wr_addr));

endmodule

`default_nettype wire

/* logic/pal_top.sv */
`timescale 1ns/1ns
`default_nettype none

module pal_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        dl_wr,
    input  logic                        downloading,
    input  pal_pkg::dl_addr_t           dl_addr,
    input  logic [pal_pkg::DW-1:0]      dl_data,
    input  logic [pal_pkg::PROM_AW-1:0] pxl_code,
    output logic                        pxl_cen,
    output logic [pal_pkg::DW-1:0]      red,
    output logic [pal_pkg::DW-1:0]      green,
    output logic [pal_pkg::DW-1:0]      blue,
    output logic                        rgb_valid,
    output logic [pal_pkg::DL_AW:0]     dl_count
);
    import pal_pkg::*;

    // registered write port shared by all four proms
    logic [NPROM-1:0]   prom_we;
    logic [PROM_AW-1:0] prom_addr;
    logic [DW-1:0]      prom_data;

    pal_dl_router router0 (
        .clk         (clk),
        .rst         (rst),
        .dl_wr       (dl_wr),
        .downloading (downloading),
        .dl_addr     (dl_addr),
        .dl_data     (dl_data),
        .prom_we     (prom_we),
        .prom_addr   (prom_addr),
        .prom_data   (prom_data),
        .dl_count    (dl_count)
    );

    // pixel enable also goes out for the video side
    pal_cen_gen cen0 (
        .clk     (clk),
        .rst     (rst),
        .pxl_cen (pxl_cen)
    );

    pal_lookup lookup0 (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .pxl_code  (pxl_code),
        .prom_we   (prom_we),
        .prom_addr (prom_addr),
        .prom_data (prom_data),
        .red       (red),
        .green     (green),
        .blue      (blue),
        .rgb_valid (rgb_valid)
    );

endmodule

`default_nettype wire

/* tb.f */
logic/pal_pkg.sv
logic/pal_prom.sv
logic/pal_dl_router.sv
logic/pal_cen_gen.sv
logic/pal_lookup.sv
logic/pal_top.sv
bench/pal_checker.sv
bench/pal_tb.sv
